//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing -j 0 --timescale 1ns/1ps
TOP       := tb_tst_result_regs
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axil/axil_read_channel.sv
/*
 * AXI4-Lite read slave, one transaction at a time.
 * Read data is sampled when the address is accepted. RRESP is always OKAY.
 */
module axil_read_channel (
	input  logic                     ACLK,
	input  logic                     ARESET,
	input  tst_result_pkg::axi_addr_t araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output tst_result_pkg::axi_data_t rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	output tst_result_pkg::reg_addr_t rd_addr,
	input  tst_result_pkg::axi_data_t rd_data
);
	import tst_result_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	rd_state_t state;
	logic      ar_hs;

	assign arready = (state == RD_IDLE);
	assign rvalid  = (state == RD_DATA);
	assign rresp   = RESP_OKAY;
	assign ar_hs   = arvalid & arready;

	// lookup address straight from the bus
	assign rd_addr = araddr[$bits(reg_addr_t)-1:0];

	// held until the R handshake, since no new AR is taken in RD_DATA
	always_ff @(posedge ACLK) begin
		if (ar_hs)
			rdata <= rd_data;
	end

	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: if (ar_hs) state <= RD_DATA;
				RD_DATA: if (rready) state <= RD_IDLE;
			endcase
		end
	end

endmodule

//--- axil/axil_write_channel.sv
/*
 * AXI4-Lite write slave, one transaction at a time.
 * AW must come before W; a W beat offered early waits for the address.
 * BRESP is always OKAY.
 */
module axil_write_channel (
	input  logic                     ACLK,
	input  logic                     ARESET,
	input  tst_result_pkg::axi_addr_t awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  tst_result_pkg::axi_data_t wdata,
	input  tst_result_pkg::axi_strb_t wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	output tst_result_pkg::reg_wr_t   reg_wr
);
	import tst_result_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	wr_state_t state;
	reg_addr_t waddr;
	logic      aw_hs;
	logic      w_hs;

	assign awready = (state == WR_IDLE);
	assign wready  = (state == WR_DATA);
	assign bvalid  = (state == WR_RESP);
	assign bresp   = RESP_OKAY;

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;

	// register write lands on the W handshake edge
	assign reg_wr.en   = w_hs;
	assign reg_wr.addr = waddr;
	assign reg_wr.data = wdata;
	assign reg_wr.strb = wstrb;

	always_ff @(posedge ACLK) begin
		if (aw_hs)
			waddr <= awaddr[$bits(reg_addr_t)-1:0];
	end

	always_ff @(posedge ACLK) begin
		if (ARESET) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: if (aw_hs) state <= WR_DATA;
				WR_DATA: if (w_hs) state <= WR_RESP;
				WR_RESP: if (bready) state <= WR_IDLE;
				default: state <= WR_IDLE;
			endcase
		end
	end

endmodule

//--- common/tst_result_config.svh
/*
 * Widths, channel count and register map of the link test result block.
 * Addresses are byte offsets and only the low TST_REG_ADDR_W bits are decoded.
 */
`ifndef TST_RESULT_CONFIG_SVH
`define TST_RESULT_CONFIG_SVH

// bus
`define TST_ADDR_W          8
`define TST_DATA_W          32
`define TST_REG_ADDR_W      6

// channels
`define TST_NUM_CHANNELS    64
`define TST_CNT_W           48
`define TST_LAT_W           16

// register map
`define TST_ADDR_CTRL       'h20
`define TST_ADDR_ASEL       'h28
`define TST_ADDR_RES0       'h2C
`define TST_ADDR_RES1       'h30
`define TST_ADDR_RES2       'h34
`define TST_ADDR_RES3       'h38
`define TST_ADDR_RES4       'h3C

`endif

//--- common/tst_result_pkg.sv
/*
 * Types shared by the result register block and its testbench.
 * Widths come from tst_result_config.svh.
 */
`include "tst_result_config.svh"

package tst_result_pkg;

	// ------------------------------
	// bus and register vectors
	// ------------------------------
	typedef logic [`TST_ADDR_W-1:0]                axi_addr_t;
	typedef logic [`TST_DATA_W-1:0]                axi_data_t;
	typedef logic [`TST_DATA_W/8-1:0]              axi_strb_t;
	typedef logic [`TST_REG_ADDR_W-1:0]            reg_addr_t;
	typedef logic [$clog2(`TST_NUM_CHANNELS)-1:0]  chan_sel_t;

	// ------------------------------
	// channel results
	// ------------------------------
	typedef logic [`TST_CNT_W-1:0] count_t;
	typedef logic [`TST_LAT_W-1:0] lat_t;

	typedef struct packed {
		count_t smp;
		count_t err;
		count_t idl;
		lat_t   lat;
	} chan_result_t;

	typedef chan_result_t [`TST_NUM_CHANNELS-1:0] chan_results_t;

	// one register write, valid for a single cycle when en is set
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		axi_data_t data;
		axi_strb_t strb;
	} reg_wr_t;

	// ------------------------------
	// FSM states
	// ------------------------------
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_t;

endpackage

//--- design/channel_snapshot.sv
/*
 * Registered copy of the selected channel's counters, refreshed every cycle.
 * A selector beyond the channel count gives all ones.
 */
`include "tst_result_config.svh"

module channel_snapshot (
	input  logic                         ACLK,
	input  tst_result_pkg::chan_sel_t     sel,
	input  tst_result_pkg::chan_results_t results,
	output tst_result_pkg::chan_result_t  snap
);
	import tst_result_pkg::*;

	logic in_range;

	// always true for a power-of-two channel count
	assign in_range = (int'(sel) < `TST_NUM_CHANNELS);

	always_ff @(posedge ACLK) begin
		if (in_range)
			snap <= results[sel];
		else
			snap <= '1;
	end

endmodule

//--- design/result_reg_map.sv
/*
 * Channel selector register and the read map of the result block.
 * The selector needs byte strobe 0; all other writes are ignored.
 */
`include "tst_result_config.svh"

module result_reg_map (
	input  logic                         ACLK,
	input  logic                         ARESET,
	input  tst_result_pkg::reg_wr_t       reg_wr,
	input  logic                         test_en,
	input  logic                         r_done,
	input  tst_result_pkg::chan_result_t  snap,
	input  tst_result_pkg::reg_addr_t     rd_addr,
	output tst_result_pkg::axi_data_t     rd_data,
	output tst_result_pkg::chan_sel_t     sel
);
	import tst_result_pkg::*;

	// low part of each counter that shares a word
	localparam int LO_W = `TST_CNT_W - `TST_DATA_W;

	logic sel_we;

	// ------------------------------
	// selector write
	// ------------------------------
	assign sel_we = reg_wr.en && reg_wr.strb[0] &&
		(reg_wr.addr == reg_addr_t'(`TST_ADDR_ASEL));

	always_ff @(posedge ACLK) begin
		if (ARESET)
			sel <= '0;
		else if (sel_we)
			sel <= reg_wr.data[$bits(chan_sel_t)-1:0];
	end

	// ------------------------------
	// read lookup
	// ------------------------------
	always_comb begin
		case (rd_addr)
			reg_addr_t'(`TST_ADDR_CTRL): rd_data = axi_data_t'({r_done, 15'd0, test_en});
			reg_addr_t'(`TST_ADDR_ASEL): rd_data = axi_data_t'(sel);
			reg_addr_t'(`TST_ADDR_RES0): rd_data = snap.smp[`TST_CNT_W-1 -: `TST_DATA_W];
			reg_addr_t'(`TST_ADDR_RES1): rd_data = snap.err[`TST_CNT_W-1 -: `TST_DATA_W];
			reg_addr_t'(`TST_ADDR_RES2): rd_data = {snap.err[LO_W-1:0], snap.smp[LO_W-1:0]};
			reg_addr_t'(`TST_ADDR_RES3): rd_data = snap.idl[`TST_CNT_W-1 -: `TST_DATA_W];
			reg_addr_t'(`TST_ADDR_RES4): rd_data = {snap.idl[LO_W-1:0], snap.lat};
			default:                     rd_data = '0;
		endcase
	end

endmodule

//--- design/tst_result_regs.sv
/*
 * Link test result registers behind an AXI4-Lite slave.
 * Results appear two cycles after a selector write; reads issued earlier
 * may still return the previous channel.
 */
module tst_result_regs (
	input  logic                         ACLK,
	input  logic                         ARESET,
	input  tst_result_pkg::axi_addr_t     AWADDR,
	input  logic                         AWVALID,
	output logic                         AWREADY,
	input  tst_result_pkg::axi_data_t     WDATA,
	input  tst_result_pkg::axi_strb_t     WSTRB,
	input  logic                         WVALID,
	output logic                         WREADY,
	output logic [1:0]                   BRESP,
	output logic                         BVALID,
	input  logic                         BREADY,
	input  tst_result_pkg::axi_addr_t     ARADDR,
	input  logic                         ARVALID,
	output logic                         ARREADY,
	output tst_result_pkg::axi_data_t     RDATA,
	output logic [1:0]                   RRESP,
	output logic                         RVALID,
	input  logic                         RREADY,
	input  logic                         test_en,
	input  logic                         r_done,
	input  tst_result_pkg::chan_results_t results
);
	import tst_result_pkg::*;

	reg_wr_t      reg_wr;
	chan_sel_t    sel;
	chan_result_t snap;
	reg_addr_t    rd_addr;
	axi_data_t    rd_data;

	// ------------------------------
	// bus side
	// ------------------------------
	axil_write_channel wr_ch_i (
		.ACLK    (ACLK),
		.ARESET  (ARESET),
		.awaddr  (AWADDR),
		.awvalid (AWVALID),
		.awready (AWREADY),
		.wdata   (WDATA),
		.wstrb   (WSTRB),
		.wvalid  (WVALID),
		.wready  (WREADY),
		.bresp   (BRESP),
		.bvalid  (BVALID),
		.bready  (BREADY),
		.reg_wr  (reg_wr)
	);

	axil_read_channel rd_ch_i (
		.ACLK    (ACLK),
		.ARESET  (ARESET),
		.araddr  (ARADDR),
		.arvalid (ARVALID),
		.arready (ARREADY),
		.rdata   (RDATA),
		.rresp   (RRESP),
		.rvalid  (RVALID),
		.rready  (RREADY),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// ------------------------------
	// registers and snapshot
	// ------------------------------
	result_reg_map reg_map_i (
		.ACLK    (ACLK),
		.ARESET  (ARESET),
		.reg_wr  (reg_wr),
		.test_en (test_en),
		.r_done  (r_done),
		.snap    (snap),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.sel     (sel)
	);

	channel_snapshot snap_i (
		.ACLK    (ACLK),
		.sel     (sel),
		.results (results),
		.snap    (snap)
	);

endmodule

//--- dv/tb_tst_result_regs.sv
/*
 * Table-driven testbench for the result registers, one AXI4-Lite transaction at a time.
 * Channel counters are filled from an LFSR at time zero and never change.
 */
`include "tst_result_config.svh"

module tb_tst_result_regs;
	timeunit 1ns;
	timeprecision 1ps;
	import tst_result_pkg::*;

	typedef struct packed {
		logic       wr;
		axi_addr_t  addr;
		axi_data_t  data;
		axi_strb_t  strb;
		logic       test_en;
		logic       r_done;
		logic [3:0] delay;
	} step_t;

	logic          ACLK;
	logic          ARESET;
	axi_addr_t     AWADDR;
	axi_addr_t     ARADDR;
	axi_data_t     WDATA;
	axi_data_t     RDATA;
	axi_strb_t     WSTRB;
	logic          AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
	logic          ARVALID, ARREADY, RVALID, RREADY;
	logic [1:0]    BRESP;
	logic [1:0]    RRESP;
	logic          test_en;
	logic          r_done;
	chan_results_t results;

	step_t     steps[$];
	chan_sel_t sel_ref;
	int        n_checks;
	int        n_errors;

	tst_result_regs dut_i (.*);

	initial begin
		ACLK = 1'b0;
		forever #4 ACLK = ~ACLK;
	end

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
		n_checks++;
		if (got !== expected) begin
			n_errors++;
			$display("error at %0t ns: %s is 0x%08h, expected 0x%08h",
				$time, name, got, expected);
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic axi_data_t expected_read(reg_addr_t a, logic te, logic done);
		chan_result_t c;
		axi_data_t    d;
		c = (int'(sel_ref) < `TST_NUM_CHANNELS) ? results[sel_ref] : '1;
		d = '0;
		case (a)
			reg_addr_t'(`TST_ADDR_CTRL): begin
				d[0]  = te;
				d[16] = done;
			end
			reg_addr_t'(`TST_ADDR_ASEL): d[$bits(chan_sel_t)-1:0] = sel_ref;
			reg_addr_t'(`TST_ADDR_RES0): d = c.smp[47:16];
			reg_addr_t'(`TST_ADDR_RES1): d = c.err[47:16];
			reg_addr_t'(`TST_ADDR_RES2): d = {c.err[15:0], c.smp[15:0]};
			reg_addr_t'(`TST_ADDR_RES3): d = c.idl[47:16];
			reg_addr_t'(`TST_ADDR_RES4): d = {c.idl[15:0], c.lat};
			default:                     d = '0;
		endcase
		return d;
	endfunction

	// ------------------------------
	// bus driver
	// ------------------------------
	task automatic axil_write(step_t s);
		AWADDR  = s.addr;
		AWVALID = 1'b1;
		while (!AWREADY) @(negedge ACLK);
		@(negedge ACLK);
		AWVALID = 1'b0;
		WDATA   = s.data;
		WSTRB   = s.strb;
		WVALID  = 1'b1;
		while (!WREADY) @(negedge ACLK);
		@(negedge ACLK);
		WVALID = 1'b0;
		while (!BVALID) @(negedge ACLK);
		repeat (s.delay) begin
			@(negedge ACLK);
			compare_value("BVALID", 32'(BVALID), 32'd1);
		end
		compare_value("BRESP", 32'(BRESP), 32'd0);
		BREADY = 1'b1;
		@(negedge ACLK);
		BREADY = 1'b0;
	endtask

	task automatic axil_read(step_t s, output axi_data_t data);
		axi_data_t first;
		ARADDR  = s.addr;
		ARVALID = 1'b1;
		while (!ARREADY) @(negedge ACLK);
		@(negedge ACLK);
		ARVALID = 1'b0;
		// lookup address moves on, so a reloaded RDATA would show
		ARADDR  = s.addr ^ 8'h04;
		while (!RVALID) @(negedge ACLK);
		first = RDATA;
		repeat (s.delay) begin
			@(negedge ACLK);
			compare_value("RVALID", 32'(RVALID), 32'd1);
			compare_value("RDATA", RDATA, first);
		end
		compare_value("RRESP", 32'(RRESP), 32'd0);
		RREADY = 1'b1;
		@(negedge ACLK);
		RREADY = 1'b0;
		data = first;
	endtask

	// ------------------------------
	// stimulus table
	// ------------------------------
	function automatic step_t write_step(axi_addr_t a, axi_data_t d, axi_strb_t s, int dly);
		return '{1'b1, a, d, s, 1'b0, 1'b0, 4'(dly)};
	endfunction

	function automatic step_t read_step(axi_addr_t a, logic te, logic done, int dly);
		return '{1'b0, a, '0, '0, te, done, 4'(dly)};
	endfunction

	function automatic void push_result_reads(int dly);
		for (int k = 0; k < 5; k++)
			steps.push_back(read_step(axi_addr_t'(`TST_ADDR_RES0 + 4 * k), 1'b0, 1'b0, dly));
	endfunction

	function automatic void build_table();
		steps.push_back(read_step(`TST_ADDR_ASEL, 1'b0, 1'b0, 0));
		push_result_reads(0);
		steps.push_back(read_step(`TST_ADDR_CTRL, 1'b0, 1'b0, 0));
		steps.push_back(read_step(`TST_ADDR_CTRL, 1'b1, 1'b0, 1));
		steps.push_back(read_step(`TST_ADDR_CTRL, 1'b0, 1'b1, 0));
		steps.push_back(read_step(`TST_ADDR_CTRL, 1'b1, 1'b1, 2));
		// upper data bits never reach the selector
		steps.push_back(write_step(`TST_ADDR_ASEL, 32'hffff_ff05, 4'hf, 0));
		steps.push_back(read_step(`TST_ADDR_ASEL, 1'b0, 1'b0, 0));
		push_result_reads(1);
		steps.push_back(write_step(`TST_ADDR_ASEL, 32'h0000_003f, 4'h1, 2));
		push_result_reads(0);
		steps.push_back(write_step(`TST_ADDR_ASEL, 32'h0000_002a, 4'h1, 5));
		push_result_reads(4);
		// none of these may move the selector
		steps.push_back(write_step(`TST_ADDR_ASEL, 32'h0000_0011, 4'he, 0));
		steps.push_back(write_step(`TST_ADDR_RES0, 32'h0000_0003, 4'hf, 1));
		steps.push_back(write_step(`TST_ADDR_CTRL, 32'hffff_ffff, 4'hf, 0));
		steps.push_back(write_step(8'h00, 32'h0000_0007, 4'hf, 0));
		steps.push_back(read_step(`TST_ADDR_ASEL, 1'b0, 1'b0, 3));
		push_result_reads(0);
		steps.push_back(read_step(8'h00, 1'b1, 1'b1, 0));
		steps.push_back(read_step(8'h24, 1'b1, 1'b1, 0));
		steps.push_back(read_step(8'h40, 1'b1, 1'b1, 1));
	endfunction

	initial begin
		logic [31:0] lfsr;
		axi_data_t   got;
		ARESET = 1'b1;
		{AWVALID, WVALID, BREADY, ARVALID, RREADY, test_en, r_done} = '0;
		{AWADDR, ARADDR, WDATA, WSTRB} = '0;
		lfsr = 32'hddcb_1f8b;
		for (int c = 0; c < `TST_NUM_CHANNELS; c++) begin
			for (int b = 0; b < $bits(chan_result_t); b++) begin
				results[c][b] = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
		end
		n_checks = 0;
		n_errors = 0;
		sel_ref  = '0;
		build_table();
		repeat (3) @(posedge ACLK);
		@(negedge ACLK);
		ARESET = 1'b0;
		compare_value("{AWREADY,ARREADY,WREADY,BVALID,RVALID}",
			32'({AWREADY, ARREADY, WREADY, BVALID, RVALID}), 32'b11000);
		foreach (steps[i]) begin
			test_en = steps[i].test_en;
			r_done  = steps[i].r_done;
			if (steps[i].wr) begin
				axil_write(steps[i]);
				if (steps[i].addr[`TST_REG_ADDR_W-1:0] == reg_addr_t'(`TST_ADDR_ASEL) &&
					steps[i].strb[0])
					sel_ref = steps[i].data[$bits(chan_sel_t)-1:0];
			end else begin
				axil_read(steps[i], got);
				compare_value($sformatf("RDATA at 0x%02h", steps[i].addr), got,
					expected_read(steps[i].addr[`TST_REG_ADDR_W-1:0], steps[i].test_en,
					steps[i].r_done));
			end
		end
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// limit scales with the table, which is built at time zero
	initial begin
		int cycles;
		int limit;
		cycles = 0;
		@(posedge ACLK);
		limit = steps.size() * 30 + 10;
		while (cycles < limit) begin
			@(posedge ACLK);
			cycles++;
		end
		$display("timeout after %0d cycles, a bus handshake never completed", limit);
		$display("tests failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+common
common/tst_result_pkg.sv
axil/axil_write_channel.sv
axil/axil_read_channel.sv
design/result_reg_map.sv
design/channel_snapshot.sv
design/tst_result_regs.sv
dv/tb_tst_result_regs.sv
